// File: stream_addr.f
hdl/stream_cfg_pkg.sv
hdl/stream_addr_pkg.sv
hdl/stream_cfg_decode.sv
hdl/stream_loop_step.sv
hdl/stream_strb_result.sv
hdl/stream_addr_top.sv
dv/tb_stream_addr.sv

// File: run_sim.sh
#!/bin/sh
# build the strided address generator testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_stream_addr \
  -f stream_addr.f -o tb_stream_addr || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_stream_addr)
echo "$out"
echo "$out" | grep -q '^>>> PASS$' && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: dv/tb_stream_addr.sv
//######################################################################
// testbench for the strided address generator with stimulus table,
// reference walk, checks, watchdog and summary
//######################################################################

`timescale 1ns/1ns

module tb_stream_addr
  import stream_cfg_pkg::*;
  import stream_addr_pkg::*;
();

  localparam int NUM_ROWS   = 6;
  localparam int ROW_CYCLES = 200;
  localparam int CLK_PERIOD = 20;

  logic              clk_i, rst_ni, cfg_we_i, start_i, enable_i;
  logic [2:0]        cfg_idx_i;
  logic [31:0]       cfg_wdata_i;
  logic [ADDR_W-1:0] addr_o;
  logic [STEP-1:0]   strb_o;
  logic              first_o, last_o, realign_o, busy_o, done_o;

  // one row per test with 1-based lengths and roll count
  string       row_name  [NUM_ROWS] = '{"aligned_line", "neg_line_stride", "inner_roll",
                                        "outer_roll", "misaligned_base", "done_and_hold"};
  logic [31:0] row_base  [NUM_ROWS] = '{32'h1000, 32'h2000, 32'h3000,
                                        32'h4000, 32'h5001, 32'h6000};
  logic [15:0] row_lstr  [NUM_ROWS] = '{16'h0, 16'hffc0, 16'h20, 16'h10, 16'h40, 16'h100};
  logic [15:0] row_llen  [NUM_ROWS] = '{16'd8, 16'd4, 16'd2, 16'd2, 16'd3, 16'd3};
  logic [15:0] row_fstr  [NUM_ROWS] = '{16'h0, 16'h0, 16'h100, 16'h200, 16'h0, 16'h0};
  logic [15:0] row_flen  [NUM_ROWS] = '{16'd1, 16'd3, 16'd2, 16'd2, 16'd2, 16'd2};
  logic [15:0] row_roll  [NUM_ROWS] = '{16'd0, 16'd0, 16'd2, 16'd2, 16'd0, 16'd0};
  logic        row_outer [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  logic [31:0] row_size  [NUM_ROWS] = '{32'd8, 32'd12, 32'd16, 32'd16, 32'd6, 32'd5};

  // reference walker state
  int          ref_w, ref_l, ref_f, ref_xfer, ref_last;
  logic [31:0] ref_woff, ref_loff, ref_foff;
  logic        ref_mis;

  int          row_errs, total_errs, n_pass, n_fail, words, idle;
  string       cur_name;
  logic        exp_done;

  stream_addr_top UUT (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic tick();
    @(posedge clk_i);
    #2;  // drive just after the edge
  endtask

  task automatic mismatch(input string what, input logic [31:0] exp_v, act_v);
    $display("Error %s: %s expected %0h actual %0h", cur_name, what, exp_v, act_v);
    row_errs++;
  endtask

  task automatic cfg_write(input logic [2:0] idx, input logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_idx_i   = idx;
    cfg_wdata_i = data;
    tick();
  endtask

  function automatic logic [31:0] sext(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic ref_start(input int r);
    ref_w    = 0;
    ref_l    = 0;
    ref_f    = 0;
    ref_xfer = 0;
    ref_woff = '0;
    ref_loff = '0;
    ref_foff = '0;
    ref_mis  = (row_base[r][1:0] != 0) || (row_lstr[r][1:0] != 0) || (row_fstr[r][1:0] != 0);
    ref_last = int'(row_llen[r]) - 1 + (ref_mis ? 1 : 0);  // one extra word when realigning
  endtask

  task automatic ref_advance(input int r);
    logic wrap;
    if (!(ref_mis && ref_w == 0)) ref_xfer++;  // leading realign word not counted
    if (ref_w != ref_last) begin
      ref_w++;
      ref_woff += 32'd4;
    end else begin
      ref_w    = 0;
      ref_woff = '0;
      if (ref_l != int'(row_flen[r]) - 1) begin
        ref_l++;
        ref_loff += sext(row_lstr[r]);
      end else begin
        ref_l    = 0;
        ref_loff = '0;
        wrap  = (row_roll[r] != 0) && (ref_f == int'(row_roll[r]) - 1);
        ref_f = wrap ? 0 : ref_f + 1;
        if (row_outer[r]) begin
          if (wrap) ref_foff += sext(row_fstr[r]);
        end else begin
          ref_foff = wrap ? '0 : ref_foff + sext(row_fstr[r]);
        end
      end
    end
  endtask

  task automatic check_word(input int r);
    logic [31:0] byte_addr, exp_addr;
    logic [3:0]  exp_strb;
    logic        exp_first, exp_last;
    byte_addr = row_base[r] + ref_foff + ref_loff + ref_woff;
    exp_addr  = {byte_addr[31:2], 2'b00};
    exp_first = ref_mis && (ref_w == 0);
    exp_last  = ref_mis && (ref_w == ref_last);
    exp_strb  = 4'hf;
    if (exp_first) exp_strb = 4'hf << byte_addr[1:0];
    if (exp_last) exp_strb = ~(4'hf << byte_addr[1:0]);  // low bytes left over
    if (addr_o !== exp_addr) mismatch("addr_o", exp_addr, addr_o);
    if (strb_o !== exp_strb) mismatch("strb_o", 32'(exp_strb), 32'(strb_o));
    if (first_o !== exp_first) mismatch("first_o", 32'(exp_first), 32'(first_o));
    if (last_o !== exp_last) mismatch("last_o", 32'(exp_last), 32'(last_o));
    if (realign_o !== ref_mis) mismatch("realign_o", 32'(ref_mis), 32'(realign_o));
  endtask

  // watchdog
  initial begin
    #((NUM_ROWS * ROW_CYCLES + 50) * CLK_PERIOD);
    $display("watchdog: run did not finish in %0d cycles, timed out",
             NUM_ROWS * ROW_CYCLES + 50);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_idx_i   = '0;
    cfg_wdata_i = '0;
    start_i     = 1'b0;
    enable_i    = 1'b0;
    void'($urandom(32'hbb51));
    total_errs = 0;
    n_pass     = 0;
    n_fail     = 0;
    row_errs   = 0;
    repeat (3) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    tick();
    cur_name = "reset";
    if (busy_o !== 1'b0 || done_o !== 1'b0) mismatch("busy/done", 32'h0, {busy_o, done_o});
    if (strb_o !== 4'hf) mismatch("strb_o", 32'hf, 32'(strb_o));
    total_errs += row_errs;

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name = row_name[r];
      row_errs = 0;
      words    = 0;
      cfg_write(REG_BASE, row_base[r]);
      cfg_write(REG_LINE, {row_lstr[r], row_llen[r]});
      cfg_write(REG_FEAT, {row_fstr[r], row_flen[r]});
      cfg_write(REG_ROLL, {row_roll[r], row_outer[r], 15'd0});
      cfg_write(REG_SIZE, row_size[r]);
      cfg_we_i = 1'b0;
      repeat (2) tick();  // misaligned level settles
      start_i = 1'b1;
      tick();
      start_i = 1'b0;
      ref_start(r);
      if (busy_o !== 1'b1 || done_o !== 1'b0) begin
        $display("%s: busy_o/done_o not in progress state after start", cur_name);
        row_errs++;
      end
      while (ref_xfer < int'(row_size[r])) begin
        idle = $urandom % 3;
        repeat (idle) begin
          check_word(r);  // outputs hold while enable is low
          tick();
        end
        check_word(r);
        enable_i = 1'b1;
        tick();
        enable_i = 1'b0;
        ref_advance(r);
        words++;
        exp_done = (ref_xfer == int'(row_size[r]));
        if (done_o !== exp_done) mismatch("done_o", 32'(exp_done), 32'(done_o));
        if (busy_o !== !exp_done) mismatch("busy_o", 32'(!exp_done), 32'(busy_o));
      end
      repeat (3) tick();
      check_word(r);  // walker parked on the word after the last one
      if (done_o !== 1'b1) mismatch("done_o held", 32'h1, 32'(done_o));
      $display("test %-16s %s, %0d words, %0d errors", cur_name,
               (row_errs == 0) ? "ok" : "failed", words, row_errs);
      if (row_errs == 0) n_pass++;
      else n_fail++;
      total_errs += row_errs;
    end

    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             NUM_ROWS, n_pass, n_fail, total_errs);
    if (total_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/stream_addr_top.sv
//######################################################################
// strided address generator top, decode plus stepping plus result
//######################################################################

`timescale 1ns/1ns

module stream_addr_top
  import stream_cfg_pkg::*;
  import stream_addr_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cfg_we_i,
  input  logic [2:0]        cfg_idx_i,
  input  logic [31:0]       cfg_wdata_i,
  input  logic              start_i,
  input  logic              enable_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic [STEP-1:0]   strb_o,
  output logic              first_o,
  output logic              last_o,
  output logic              realign_o,
  output logic              busy_o,
  output logic              done_o
);

  logic [31:0]       base_addr, xfer_size;
  logic [CFG_W-1:0]  line_stride, line_len, feat_stride, feat_len, feat_roll;
  logic              loop_outer, misaligned;
  logic [ADDR_W-1:0] offset;
  logic              word_first, word_last;

  stream_cfg_decode u_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .base_addr_o   (base_addr),
    .line_stride_o (line_stride),
    .line_len_o    (line_len),
    .feat_stride_o (feat_stride),
    .feat_len_o    (feat_len),
    .feat_roll_o   (feat_roll),
    .loop_outer_o  (loop_outer),
    .xfer_size_o   (xfer_size),
    .misaligned_o  (misaligned)
  );

  stream_loop_step u_step (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .enable_i      (enable_i),
    .line_stride_i (line_stride),
    .line_len_i    (line_len),
    .feat_stride_i (feat_stride),
    .feat_len_i    (feat_len),
    .feat_roll_i   (feat_roll),
    .loop_outer_i  (loop_outer),
    .xfer_size_i   (xfer_size),
    .misaligned_i  (misaligned),
    .offset_o      (offset),
    .word_first_o  (word_first),
    .word_last_o   (word_last),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

  stream_strb_result u_result (
    .base_addr_i  (base_addr),
    .offset_i     (offset),
    .misaligned_i (misaligned),
    .word_first_i (word_first),
    .word_last_i  (word_last),
    .addr_o       (addr_o),
    .strb_o       (strb_o),
    .first_o      (first_o),
    .last_o       (last_o),
    .realign_o    (realign_o)
  );

endmodule

// File: hdl/stream_strb_result.sv
//######################################################################
// aligned output address, byte strobe and realign marks
//######################################################################

`timescale 1ns/1ns

module stream_strb_result
  import stream_addr_pkg::*;
(
  input  logic [ADDR_W-1:0] base_addr_i,
  input  logic [ADDR_W-1:0] offset_i,
  input  logic              misaligned_i,
  input  logic              word_first_i,
  input  logic              word_last_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic [STEP-1:0]   strb_o,
  output logic              first_o,
  output logic              last_o,
  output logic              realign_o
);

  logic [ADDR_W-1:0] byte_addr;
  logic [OFFS_W-1:0] byte_offs;
  logic [STEP-1:0]   strb_shift;

  assign byte_addr = base_addr_i + offset_i;
  assign byte_offs = byte_addr[OFFS_W-1:0];

  // word aligned, low bits dropped
  assign addr_o = {byte_addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};

  // bytes at and above the offset
  assign strb_shift = STRB_ALL << byte_offs;

  always_comb begin
    strb_o = STRB_ALL;
    if (misaligned_i) begin
      if (word_first_i) begin
        strb_o = strb_shift;
      end
      if (word_last_i) begin
        strb_o = ~strb_shift;  // remaining low bytes of the line
      end
    end
  end

  // marks only meaningful while realigning
  assign first_o   = misaligned_i & word_first_i;
  assign last_o    = misaligned_i & word_last_i;
  assign realign_o = misaligned_i;

endmodule

// File: hdl/stream_loop_step.sv
//######################################################################
// three nested loop counters with byte accumulators
// and the transfer word counter with busy and done levels
//######################################################################

`timescale 1ns/1ns

module stream_loop_step
  import stream_cfg_pkg::*;
  import stream_addr_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  logic              enable_i,
  input  logic [CFG_W-1:0]  line_stride_i,
  input  logic [CFG_W-1:0]  line_len_i,
  input  logic [CFG_W-1:0]  feat_stride_i,
  input  logic [CFG_W-1:0]  feat_len_i,
  input  logic [CFG_W-1:0]  feat_roll_i,
  input  logic              loop_outer_i,
  input  logic [31:0]       xfer_size_i,
  input  logic              misaligned_i,
  output logic [ADDR_W-1:0] offset_o,
  output logic              word_first_o,
  output logic              word_last_o,
  output logic              busy_o,
  output logic              done_o
);

  logic [CNT_W-1:0]  word_cnt_q, line_cnt_q, feat_cnt_q;
  logic [ADDR_W-1:0] word_addr_q, line_addr_q, feat_addr_q;
  logic [XFER_W-1:0] xfer_cnt_q;
  logic              busy_q, done_q;
  logic [CFG_W-1:0]  word_cnt_ext, line_cnt_ext, feat_cnt_ext;
  logic [CFG_W-1:0]  line_last, feat_last;
  logic [ADDR_W-1:0] line_step, feat_step;
  logic              word_end, line_end, roll_wrap;
  logic              step, counted, final_word;

  assign word_cnt_ext = CFG_W'(word_cnt_q);
  assign line_cnt_ext = CFG_W'(line_cnt_q);
  assign feat_cnt_ext = CFG_W'(feat_cnt_q);

  // realign emits one extra word per line
  assign line_last = misaligned_i ? line_len_i : line_len_i - 1'b1;
  assign feat_last = feat_len_i - 1'b1;

  assign word_end  = (word_cnt_ext == line_last);
  assign line_end  = (line_cnt_ext == feat_last);
  assign roll_wrap = (feat_roll_i != '0) && (feat_cnt_ext == feat_roll_i - 1'b1);

  // signed strides into address width
  assign line_step = {{(ADDR_W-CFG_W){line_stride_i[CFG_W-1]}}, line_stride_i};
  assign feat_step = {{(ADDR_W-CFG_W){feat_stride_i[CFG_W-1]}}, feat_stride_i};

  assign step       = enable_i & busy_q;
  assign counted    = !(misaligned_i && (word_cnt_q == '0));  // first word of line is extra
  assign final_word = step && counted &&
                      ({{(32-XFER_W){1'b0}}, xfer_cnt_q} == (xfer_size_i - 32'd1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q  <= '0;
      line_cnt_q  <= '0;
      feat_cnt_q  <= '0;
      word_addr_q <= '0;
      line_addr_q <= '0;
      feat_addr_q <= '0;
      xfer_cnt_q  <= '0;
    end else if (start_i) begin
      word_cnt_q  <= '0;
      line_cnt_q  <= '0;
      feat_cnt_q  <= '0;
      word_addr_q <= '0;
      line_addr_q <= '0;
      feat_addr_q <= '0;
      xfer_cnt_q  <= '0;
    end else if (step) begin
      if (!word_end) begin
        word_addr_q <= word_addr_q + ADDR_W'(STEP);
        word_cnt_q  <= word_cnt_q + 1'b1;
      end else begin
        word_addr_q <= '0;
        word_cnt_q  <= '0;
        if (!line_end) begin
          line_addr_q <= line_addr_q + line_step;
          line_cnt_q  <= line_cnt_q + 1'b1;
        end else begin
          line_addr_q <= '0;
          line_cnt_q  <= '0;
          feat_cnt_q  <= roll_wrap ? '0 : feat_cnt_q + 1'b1;
          if (loop_outer_i) begin
            if (roll_wrap) feat_addr_q <= feat_addr_q + feat_step;  // outer only on wrap
          end else begin
            feat_addr_q <= roll_wrap ? '0 : feat_addr_q + feat_step;
          end
        end
      end
      if (counted) xfer_cnt_q <= xfer_cnt_q + 1'b1;
    end
  end

  // done holds until the next start
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
    end else if (final_word) begin
      busy_q <= 1'b0;
      done_q <= 1'b1;
    end
  end

  assign offset_o     = feat_addr_q + line_addr_q + word_addr_q;
  assign word_first_o = (word_cnt_q == '0);
  assign word_last_o  = word_end;
  assign busy_o       = busy_q;
  assign done_o       = done_q;

  a_word_in_line: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    busy_q |-> (word_cnt_ext <= line_last)
  );

  // consumer stops once the transfer is over
  a_no_enable_after_done: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_q |-> !enable_i
  );

endmodule

// File: hdl/stream_cfg_decode.sv
//######################################################################
// host register decode into held configuration fields
// plus the registered misalignment level
//######################################################################

`timescale 1ns/1ns

module stream_cfg_decode
  import stream_cfg_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             cfg_we_i,
  input  logic [2:0]       cfg_idx_i,
  input  logic [31:0]      cfg_wdata_i,
  output logic [31:0]      base_addr_o,
  output logic [CFG_W-1:0] line_stride_o,
  output logic [CFG_W-1:0] line_len_o,
  output logic [CFG_W-1:0] feat_stride_o,
  output logic [CFG_W-1:0] feat_len_o,
  output logic [CFG_W-1:0] feat_roll_o,
  output logic             loop_outer_o,
  output logic [31:0]      xfer_size_o,
  output logic             misaligned_o
);

  cfg_word_u wdata;
  logic      misaligned_d;

  assign wdata = cfg_wdata_i;

  // field registers, one write per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_addr_o   <= '0;
      line_stride_o <= '0;
      line_len_o    <= '0;
      feat_stride_o <= '0;
      feat_len_o    <= '0;
      feat_roll_o   <= '0;
      loop_outer_o  <= 1'b0;
      xfer_size_o   <= '0;
    end else if (cfg_we_i) begin
      case (cfg_idx_i)
        REG_BASE: base_addr_o <= wdata.word;
        REG_LINE: begin
          line_stride_o <= wdata.half.stride;
          line_len_o    <= wdata.half.len;
        end
        REG_FEAT: begin
          feat_stride_o <= wdata.half.stride;
          feat_len_o    <= wdata.half.len;
        end
        REG_ROLL: begin
          feat_roll_o  <= wdata.half.stride;
          loop_outer_o <= wdata.half.len[15];  // mode bit
        end
        REG_SIZE: xfer_size_o <= wdata.word;
        default: ;                             // unmapped index, ignored
      endcase
    end
  end

  // any byte offset in base or strides means a line straddles words
  assign misaligned_d = (base_addr_o[1:0] != 2'b00) ||
                        (line_stride_o[1:0] != 2'b00) ||
                        (feat_stride_o[1:0] != 2'b00);

  // one cycle behind the held fields
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      misaligned_o <= 1'b0;
    end else begin
      misaligned_o <= misaligned_d;
    end
  end

  // host only addresses the five mapped registers
  a_idx_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cfg_we_i |-> (cfg_idx_i < NUM_REGS)
  );

endmodule

// File: hdl/stream_addr_pkg.sv
//######################################################################
// word step, counter widths and strobe constants for the walker
//######################################################################

package stream_addr_pkg;

  // generated address width
  localparam int unsigned ADDR_W = 32;

  // bytes per word, also the strobe width
  localparam int unsigned STEP = 4;

  // byte offset bits inside one word
  localparam int unsigned OFFS_W = $clog2(STEP);

  // word, line and feature counters
  localparam int unsigned CNT_W = 10;

  // transfer word counter
  localparam int unsigned XFER_W = 16;

  // full word strobe, used when aligned and in the middle of a line
  localparam logic [STEP-1:0] STRB_ALL = '1;

endpackage

// File: hdl/stream_cfg_pkg.sv
//######################################################################
// configuration register map, register word view and field widths
// for the strided address generator
//######################################################################

package stream_cfg_pkg;

  // width of the length, stride and roll fields
  localparam int unsigned CFG_W = 16;

  // register indices, five registers in total
  localparam int unsigned NUM_REGS = 5;

  localparam logic [2:0] REG_BASE = 3'd0;  // whole word, base address
  localparam logic [2:0] REG_LINE = 3'd1;  // halves, line stride / line length
  localparam logic [2:0] REG_FEAT = 3'd2;  // halves, feature stride / feature length
  localparam logic [2:0] REG_ROLL = 3'd3;  // halves, roll count / loop_outer at bit 15
  localparam logic [2:0] REG_SIZE = 3'd4;  // whole word, transfer size in words

  // split view of a register write
  // stride or roll count sits in the upper half, length in the lower half
  typedef struct packed {
    logic [CFG_W-1:0] stride;
    logic [CFG_W-1:0] len;
  } cfg_half_t;

  // one write word, read either as a whole value or as two halves
  typedef union packed {
    logic [2*CFG_W-1:0] word;
    cfg_half_t          half;
  } cfg_word_u;

endpackage
